/* design/dbg_pkg.sv */
`default_nettype none

package dbg_pkg;

    // Bank sizes
    localparam int NR_BANKS     = 4;     // Debug register banks on the APB
    localparam int BANK_WORDS   = 8;     // 32-bit registers per bank
    localparam int CDPACC_WIDTH = 36;    // ACK/WR+OP plus 32 data bits

    // Plain vector types
    typedef logic [3:0]          ir_t;       // TAP instruction code
    typedef logic [31:0]         dbg_word_t; // Debug data word
    typedef logic [7:0]          paddr_t;    // APB byte address
    typedef logic [2:0]          cdp_op_t;   // CDP register select
    typedef logic [3:0]          cdp_ack_t;  // Capture-DR response code
    typedef logic [NR_BANKS-1:0] bank_sel_t; // One-hot PSEL

    // Instruction codes, unlisted codes act as BYPASS
    localparam ir_t IR_IDCODE = 4'b0001;
    localparam ir_t IR_CDPACC = 4'b1010;
    localparam ir_t IR_BYPASS = 4'b1111;

    localparam dbg_word_t IDCODE_VALUE = 32'h2C4B_0E15; // LSB set as JTAG requires

    // CDP operations, bits 3:1 of CDPACC on update
    localparam cdp_op_t CDP_OP_SELECT = 3'd0;
    localparam cdp_op_t CDP_OP_TADDR  = 3'd1;
    localparam cdp_op_t CDP_OP_DTR    = 3'd2;

    // ACK codes, bits 3:0 of CDPACC on capture
    localparam cdp_ack_t ACK_WAIT  = 4'd1;
    localparam cdp_ack_t ACK_OK    = 4'd2;
    localparam cdp_ack_t ACK_FAULT = 4'd4;

    // 16 states of IEEE 1149.1
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET, RUN_TEST_IDLE,
        SELECT_DR_SCAN, CAPTURE_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPDATE_DR,
        SELECT_IR_SCAN, CAPTURE_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
    } tap_state_t;

    typedef struct packed {
        paddr_t    paddr;   // Byte address
        logic      pwrite;  // 1 = write
        logic      penable; // Access phase
        dbg_word_t pwdata;  // Write data
    } apb_req_t;

    typedef struct packed {
        dbg_word_t prdata;  // Read data
        logic      pready;  // Transfer done
        logic      pslverr; // Error response
    } apb_rsp_t;

endpackage

`default_nettype wire

/* design/jtag_tap.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_tap (
    input  logic tck,
    input  logic state_test_logic_reset,
    input  logic tms,
    input  logic tdi,
    input  logic cdpacc_tdo,  // Bit 0 of CDPACC scan register
    output logic tdo,
    output logic capture_dr,
    output logic shift_dr,
    output logic update_dr,
    output logic cdpacc_sel
);

    dbg_pkg::tap_state_t state_q;
    dbg_pkg::tap_state_t state_nxt;
    dbg_pkg::ir_t        ir_sr;     // IR scan stage
    dbg_pkg::ir_t        ir_q;      // Committed instruction
    dbg_pkg::dbg_word_t  idcode_sr; // IDCODE scan stage
    logic                bypass_q;  // Single-bit BYPASS
    logic                idcode_sel;
    logic                dr_tdo;    // Selected DR bit 0

    // Next state on TMS
    always_comb begin
        case (state_q)
            dbg_pkg::TEST_LOGIC_RESET: state_nxt = tms ? dbg_pkg::TEST_LOGIC_RESET
                                                       : dbg_pkg::RUN_TEST_IDLE;
            dbg_pkg::RUN_TEST_IDLE:  state_nxt = tms ? dbg_pkg::SELECT_DR_SCAN
                                                     : dbg_pkg::RUN_TEST_IDLE;
            dbg_pkg::SELECT_DR_SCAN: state_nxt = tms ? dbg_pkg::SELECT_IR_SCAN
                                                     : dbg_pkg::CAPTURE_DR;
            dbg_pkg::CAPTURE_DR:     state_nxt = tms ? dbg_pkg::EXIT1_DR : dbg_pkg::SHIFT_DR;
            dbg_pkg::SHIFT_DR:       state_nxt = tms ? dbg_pkg::EXIT1_DR : dbg_pkg::SHIFT_DR;
            dbg_pkg::EXIT1_DR:       state_nxt = tms ? dbg_pkg::UPDATE_DR : dbg_pkg::PAUSE_DR;
            dbg_pkg::PAUSE_DR:       state_nxt = tms ? dbg_pkg::EXIT2_DR : dbg_pkg::PAUSE_DR;
            dbg_pkg::EXIT2_DR:       state_nxt = tms ? dbg_pkg::UPDATE_DR : dbg_pkg::SHIFT_DR;
            dbg_pkg::UPDATE_DR:      state_nxt = tms ? dbg_pkg::SELECT_DR_SCAN
                                                     : dbg_pkg::RUN_TEST_IDLE;
            dbg_pkg::SELECT_IR_SCAN: state_nxt = tms ? dbg_pkg::TEST_LOGIC_RESET
                                                     : dbg_pkg::CAPTURE_IR;
            dbg_pkg::CAPTURE_IR:     state_nxt = tms ? dbg_pkg::EXIT1_IR : dbg_pkg::SHIFT_IR;
            dbg_pkg::SHIFT_IR:       state_nxt = tms ? dbg_pkg::EXIT1_IR : dbg_pkg::SHIFT_IR;
            dbg_pkg::EXIT1_IR:       state_nxt = tms ? dbg_pkg::UPDATE_IR : dbg_pkg::PAUSE_IR;
            dbg_pkg::PAUSE_IR:       state_nxt = tms ? dbg_pkg::EXIT2_IR : dbg_pkg::PAUSE_IR;
            dbg_pkg::EXIT2_IR:       state_nxt = tms ? dbg_pkg::UPDATE_IR : dbg_pkg::SHIFT_IR;
            default:                 state_nxt = tms ? dbg_pkg::SELECT_DR_SCAN
                                                     : dbg_pkg::RUN_TEST_IDLE; // Update-IR
        endcase
    end

    always_ff @(posedge tck) begin
        if (state_test_logic_reset) begin
            state_q <= dbg_pkg::TEST_LOGIC_RESET;
        end else begin
            state_q <= state_nxt;
        end
    end

    // DR strobes to the CDP
    assign capture_dr = (state_q == dbg_pkg::CAPTURE_DR);
    assign shift_dr   = (state_q == dbg_pkg::SHIFT_DR);
    assign update_dr  = (state_q == dbg_pkg::UPDATE_DR);

    // Instruction decode
    assign cdpacc_sel = (ir_q == dbg_pkg::IR_CDPACC);
    assign idcode_sel = (ir_q == dbg_pkg::IR_IDCODE);

    always_ff @(posedge tck) begin
        if (state_test_logic_reset || state_q == dbg_pkg::TEST_LOGIC_RESET) begin
            ir_q <= dbg_pkg::IR_IDCODE;                // IDCODE out of reset
        end else if (state_q == dbg_pkg::UPDATE_IR) begin
            ir_q <= ir_sr;
        end
    end

    always_ff @(posedge tck) begin
        if (state_q == dbg_pkg::CAPTURE_IR) begin
            ir_sr <= 4'b0001;                          // Fixed capture pattern
        end else if (state_q == dbg_pkg::SHIFT_IR) begin
            ir_sr <= {tdi, ir_sr[3:1]};
        end
    end

    // Local data registers
    always_ff @(posedge tck) begin
        if (idcode_sel && capture_dr) begin
            idcode_sr <= dbg_pkg::IDCODE_VALUE;
        end else if (idcode_sel && shift_dr) begin
            idcode_sr <= {tdi, idcode_sr[31:1]};
        end
        if (capture_dr) begin
            bypass_q <= 1'b0;
        end else if (shift_dr) begin
            bypass_q <= tdi;
        end
    end

    always_comb begin
        case (ir_q)
            dbg_pkg::IR_IDCODE: dr_tdo = idcode_sr[0];
            dbg_pkg::IR_CDPACC: dr_tdo = cdpacc_tdo;
            default:            dr_tdo = bypass_q;     // BYPASS and unknown codes
        endcase
    end

    // TDO changes on the falling edge
    always_ff @(negedge tck) begin
        if (state_test_logic_reset) begin
            tdo <= 1'b0;
        end else if (state_q == dbg_pkg::SHIFT_IR) begin
            tdo <= ir_sr[0];
        end else if (shift_dr) begin
            tdo <= dr_tdo;
        end else begin
            tdo <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/core_dbg_port.sv */
`timescale 1ns/10ps
`default_nettype none

module core_dbg_port (
    input  logic                tck,
    input  logic                state_test_logic_reset,
    input  logic                tdi,
    input  logic                capture_dr,
    input  logic                shift_dr,
    input  logic                update_dr,
    input  logic                cdpacc_sel,
    input  dbg_pkg::apb_rsp_t   apb_rsp,
    output logic                cdpacc_tdo,
    output dbg_pkg::apb_req_t   apb_req,
    output dbg_pkg::bank_sel_t  psel
);

    logic [dbg_pkg::CDPACC_WIDTH-1:0] cdpacc_q; // Scan register

    logic               upd_wr;    // Update-DR fields
    dbg_pkg::cdp_op_t   upd_op;
    dbg_pkg::dbg_word_t upd_data;
    logic               cmd_valid; // Update-DR with CDPACC
    logic               dtr_start; // DTR op accepted
    logic               xfer_done; // Access phase with PREADY

    dbg_pkg::dbg_word_t select_q;
    dbg_pkg::dbg_word_t taddr_q;
    dbg_pkg::dbg_word_t dtr_q;
    dbg_pkg::dbg_word_t result_q;
    dbg_pkg::cdp_ack_t  ack_q;
    dbg_pkg::cdp_ack_t  capt_ack;
    dbg_pkg::bank_sel_t psel_dec;
    logic               busy_q;    // Transfer in flight
    logic               wait_q;    // Sticky WAIT
    logic               penable_q;
    dbg_pkg::paddr_t    paddr_q;
    logic               pwrite_q;
    dbg_pkg::dbg_word_t pwdata_q;

    assign upd_wr   = cdpacc_q[0];
    assign upd_op   = cdpacc_q[3:1];
    assign upd_data = cdpacc_q[dbg_pkg::CDPACC_WIDTH-1:4];

    assign cmd_valid = cdpacc_sel & update_dr;
    assign dtr_start = cmd_valid & (upd_op == dbg_pkg::CDP_OP_DTR) & ~busy_q;
    assign xfer_done = busy_q & penable_q & apb_rsp.pready;

    assign cdpacc_tdo = cdpacc_q[0];                   // ACK goes out first
    assign capt_ack   = (busy_q || wait_q) ? dbg_pkg::ACK_WAIT : ack_q;

    // SELECT at or above NR_BANKS selects nothing
    always_comb begin
        psel_dec = '0;
        if (select_q < dbg_pkg::NR_BANKS) begin
            psel_dec = dbg_pkg::bank_sel_t'(1) << select_q;
        end
    end

    always_ff @(posedge tck) begin
        if (cdpacc_sel && capture_dr) begin
            cdpacc_q <= {result_q, capt_ack};
        end else if (cdpacc_sel && shift_dr) begin
            cdpacc_q <= {tdi, cdpacc_q[dbg_pkg::CDPACC_WIDTH-1:1]}; // Shift toward bit 0
        end
    end

    // Command registers and requester control
    always_ff @(posedge tck) begin
        if (state_test_logic_reset) begin
            select_q  <= '0;
            taddr_q   <= '0;
            dtr_q     <= '0;
            result_q  <= '0;
            ack_q     <= dbg_pkg::ACK_OK;
            busy_q    <= 1'b0;
            wait_q    <= 1'b0;
            penable_q <= 1'b0;
            psel      <= '0;
        end else begin
            if (cmd_valid) begin
                case (upd_op)
                    dbg_pkg::CDP_OP_SELECT: begin
                        if (upd_wr) begin
                            select_q <= upd_data;
                        end else begin
                            result_q <= select_q;      // Local read, no transfer
                            ack_q    <= dbg_pkg::ACK_OK;
                        end
                    end
                    dbg_pkg::CDP_OP_TADDR: begin
                        if (upd_wr) begin
                            taddr_q <= upd_data;
                        end else begin
                            result_q <= taddr_q;
                            ack_q    <= dbg_pkg::ACK_OK;
                        end
                    end
                    dbg_pkg::CDP_OP_DTR: begin
                        if (busy_q) begin
                            wait_q <= 1'b1;            // Dropped, flag it
                        end else begin
                            if (upd_wr) begin
                                dtr_q <= upd_data;
                            end
                            busy_q <= 1'b1;
                            psel   <= psel_dec;        // Setup phase
                        end
                    end
                    default: begin
                    end
                endcase
            end else if (cdpacc_sel && capture_dr) begin
                wait_q <= 1'b0;                        // Reported once
            end

            if (busy_q && !penable_q) begin
                penable_q <= 1'b1;                     // Access phase
            end else if (xfer_done) begin
                busy_q    <= 1'b0;
                penable_q <= 1'b0;
                psel      <= '0;
                if (apb_rsp.pslverr) begin
                    ack_q    <= dbg_pkg::ACK_FAULT;
                    result_q <= '0;
                end else begin
                    ack_q    <= dbg_pkg::ACK_OK;
                    result_q <= pwrite_q ? pwdata_q : apb_rsp.prdata;
                end
            end
        end
    end

    // Request payload held for the whole transfer
    always_ff @(posedge tck) begin
        if (dtr_start) begin
            paddr_q  <= dbg_pkg::paddr_t'(taddr_q);
            pwrite_q <= upd_wr;
            pwdata_q <= upd_wr ? upd_data : dtr_q;
        end
    end

    assign apb_req = '{paddr: paddr_q, pwrite: pwrite_q, penable: penable_q, pwdata: pwdata_q};

endmodule

`default_nettype wire

/* design/dbg_reg_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_reg_bank (
    input  logic               tck,
    input  logic               state_test_logic_reset,
    input  logic               psel_i,
    input  dbg_pkg::apb_req_t  apb_req,
    output dbg_pkg::apb_rsp_t  bank_rsp
);

    localparam int IDX_W = $clog2(dbg_pkg::BANK_WORDS);

    dbg_pkg::dbg_word_t regs_q [dbg_pkg::BANK_WORDS]; // Debug registers
    logic [IDX_W-1:0]   word_idx;
    logic               addr_err;  // Misaligned or out of range
    logic               ready_q;   // High after one wait state
    logic               access;    // Access phase to this bank

    assign word_idx = apb_req.paddr[IDX_W+1:2];
    assign addr_err = (apb_req.paddr[1:0] != 2'b00) ||
                      (apb_req.paddr[7:IDX_W+2] != '0);
    assign access   = psel_i & apb_req.penable;

    // One wait state, then PREADY for a cycle
    always_ff @(posedge tck) begin
        if (state_test_logic_reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= access & ~ready_q;
        end
    end

    // Write on the completing edge
    always_ff @(posedge tck) begin
        if (state_test_logic_reset) begin
            for (int i = 0; i < dbg_pkg::BANK_WORDS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (access && ready_q && apb_req.pwrite && !addr_err) begin
            regs_q[word_idx] <= apb_req.pwdata;
        end
    end

    always_comb begin
        bank_rsp.pready  = ready_q;
        bank_rsp.pslverr = ready_q & addr_err;
        bank_rsp.prdata  = addr_err ? '0 : regs_q[word_idx]; // Bad address reads 0
    end

endmodule

`default_nettype wire

/* design/dbg_resp_collector.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_resp_collector (
    input  logic               tck,
    input  logic               state_test_logic_reset,
    input  dbg_pkg::bank_sel_t psel,
    input  dbg_pkg::apb_req_t  apb_req,
    input  dbg_pkg::apb_rsp_t  bank_rsp [dbg_pkg::NR_BANKS],
    output dbg_pkg::apb_rsp_t  apb_rsp
);

    logic unmapped;   // Access phase with no bank selected
    logic miss_wait_q; // Wait state for the unmapped answer

    assign unmapped = apb_req.penable & (psel == '0);

    always_ff @(posedge tck) begin
        if (state_test_logic_reset) begin
            miss_wait_q <= 1'b0;
        end else begin
            miss_wait_q <= unmapped & ~miss_wait_q;
        end
    end

    always_comb begin
        apb_rsp = '0;
        for (int i = 0; i < dbg_pkg::NR_BANKS; i++) begin
            if (psel[i]) begin
                apb_rsp = bank_rsp[i];             // One-hot select
            end
        end
        if (unmapped) begin
            apb_rsp.pready  = miss_wait_q;         // Same timing as a bank
            apb_rsp.pslverr = miss_wait_q;
        end
    end

endmodule

`default_nettype wire

/* design/jtag_dbg_top.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_dbg_top (
    input  logic tck,
    input  logic state_test_logic_reset,
    input  logic tms,
    input  logic tdi,
    output logic tdo
);

    logic               capture_dr;
    logic               shift_dr;
    logic               update_dr;
    logic               cdpacc_sel;
    logic               cdpacc_tdo;
    dbg_pkg::apb_req_t  apb_req;                       // Broadcast to banks
    dbg_pkg::bank_sel_t psel;
    dbg_pkg::apb_rsp_t  apb_rsp;                       // Collected response
    dbg_pkg::apb_rsp_t  bank_rsp [dbg_pkg::NR_BANKS];

    jtag_tap u_tap (
        .tck                    (tck),
        .state_test_logic_reset (state_test_logic_reset),
        .tms                    (tms),
        .tdi                    (tdi),
        .cdpacc_tdo             (cdpacc_tdo),
        .tdo                    (tdo),
        .capture_dr             (capture_dr),
        .shift_dr               (shift_dr),
        .update_dr              (update_dr),
        .cdpacc_sel             (cdpacc_sel)
    );

    core_dbg_port u_cdp (
        .tck                    (tck),
        .state_test_logic_reset (state_test_logic_reset),
        .tdi                    (tdi),
        .capture_dr             (capture_dr),
        .shift_dr               (shift_dr),
        .update_dr              (update_dr),
        .cdpacc_sel             (cdpacc_sel),
        .apb_rsp                (apb_rsp),
        .cdpacc_tdo             (cdpacc_tdo),
        .apb_req                (apb_req),
        .psel                   (psel)
    );

    for (genvar i = 0; i < dbg_pkg::NR_BANKS; i++) begin : g_bank
        dbg_reg_bank u_bank (
            .tck                    (tck),
            .state_test_logic_reset (state_test_logic_reset),
            .psel_i                 (psel[i]),
            .apb_req                (apb_req),
            .bank_rsp               (bank_rsp[i])
        );
    end

    dbg_resp_collector u_collector (
        .tck                    (tck),
        .state_test_logic_reset (state_test_logic_reset),
        .psel                   (psel),
        .apb_req                (apb_req),
        .bank_rsp               (bank_rsp),
        .apb_rsp                (apb_rsp)
    );

endmodule

`default_nettype wire

/* sim/jtag_dbg_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_dbg_asserts (
    input  logic               tck,
    input  logic               state_test_logic_reset,
    input  dbg_pkg::apb_req_t  apb_req,
    input  dbg_pkg::bank_sel_t psel,
    input  dbg_pkg::apb_rsp_t  apb_rsp,
    input  logic               busy        // CDP transfer in flight
);

    int fail_cnt = 0;                      // Read by the testbench at the end

    // Access phase exactly one cycle after the setup phase
    penable_after_setup: assert property (@(posedge tck) disable iff (state_test_logic_reset)
        $rose(apb_req.penable) |-> $past(busy) && !$past(busy, 2) && $stable(psel))
        else begin
            $error("PENABLE rose without a setup phase");
            fail_cnt++;
        end

    // Request frozen while waiting for PREADY
    req_stable: assert property (@(posedge tck) disable iff (state_test_logic_reset)
        (apb_req.penable && !apb_rsp.pready) |=> $stable(apb_req) && $stable(psel))
        else begin
            $error("APB request changed before PREADY");
            fail_cnt++;
        end

    psel_onehot: assert property (@(posedge tck) disable iff (state_test_logic_reset)
        $onehot0(psel))
        else begin
            $error("More than one PSEL bit set");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* sim/jtag_dbg_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_dbg_checker (
    input  logic        tck,
    input  logic        shift_dr,   // TAP in Shift-DR
    input  logic        tdo,
    input  logic        win_open,   // Scan window from the testbench
    input  logic [63:0] exp_word,   // Bit 0 leaves first
    input  int          exp_len,
    output logic        active,     // Window seen, compare pending
    output int          tdo_errs,
    output int          len_errs,
    output int          scans
);

    logic [63:0] got;               // Collected TDO bits
    logic [63:0] mask;
    int          cnt;

    initial begin
        active   = 1'b0;
        tdo_errs = 0;
        len_errs = 0;
        scans    = 0;
        got      = '0;
        cnt      = 0;
    end

    // TDO settles on the falling edge, sampled on the rising one
    always @(posedge tck) begin
        if (win_open) begin
            active = 1'b1;
            if (shift_dr) begin
                got[cnt] = tdo;
                cnt++;
            end
        end else if (active) begin
            mask = (exp_len >= 64) ? '1 : ((64'd1 << exp_len) - 64'd1);
            if (cnt != exp_len) begin
                $display("Scan length wrong: shifted %0d bits, expected %0d", cnt, exp_len);
                len_errs++;
            end
            if (((got ^ exp_word) & mask) != '0) begin
                $display("[ERROR] tdo expected 0x%h got 0x%h", exp_word & mask, got & mask);
                tdo_errs++;
            end
            scans++;
            got    = '0;
            cnt    = 0;
            active = 1'b0;          // Ready for the next window
        end
    end

endmodule

`default_nettype wire

/* sim/jtag_dbg_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module jtag_dbg_tb;

    localparam dbg_pkg::cdp_op_t OP_NOP = 3'd3;   // Touches no CDP register

    logic        tck;
    logic        state_test_logic_reset;
    logic        tms;
    logic        tdi;
    wire         tdo;
    logic        win_open;
    logic [63:0] exp_word;
    int          exp_len;
    logic        chk_active;
    int          tdo_errs;
    int          len_errs;
    int          scans;

    // Reference state of the CDP and banks
    dbg_pkg::dbg_word_t bank_m [dbg_pkg::NR_BANKS][dbg_pkg::BANK_WORDS];
    dbg_pkg::dbg_word_t sel_m;
    dbg_pkg::dbg_word_t taddr_m;
    dbg_pkg::dbg_word_t res_m;
    dbg_pkg::cdp_ack_t  ack_m;
    logic               busy_m;                   // Transfer still running at next capture
    dbg_pkg::dbg_word_t pend_res;
    dbg_pkg::cdp_ack_t  pend_ack;
    logic [7:0]         wr_addr [dbg_pkg::NR_BANKS][3];

    jtag_dbg_top DUT (
        .tck                    (tck),
        .state_test_logic_reset (state_test_logic_reset),
        .tms                    (tms),
        .tdi                    (tdi),
        .tdo                    (tdo)
    );

    jtag_dbg_checker u_checker (
        .tck      (tck),
        .shift_dr (DUT.shift_dr),
        .tdo      (tdo),
        .win_open (win_open),
        .exp_word (exp_word),
        .exp_len  (exp_len),
        .active   (chk_active),
        .tdo_errs (tdo_errs),
        .len_errs (len_errs),
        .scans    (scans)
    );

    bind core_dbg_port jtag_dbg_asserts u_asserts (
        .tck                    (tck),
        .state_test_logic_reset (state_test_logic_reset),
        .apb_req                (apb_req),
        .psel                   (psel),
        .apb_rsp                (apb_rsp),
        .busy                   (busy_q)
    );

    initial begin
        tck = 1'b0;
        forever #2 tck = ~tck;                    // 4 ns period
    end

    // Capture word {result, ack} seen by the next Capture-DR
    function automatic logic [35:0] expected_capture(input logic busy,
                                                     input dbg_pkg::cdp_ack_t ack,
                                                     input dbg_pkg::dbg_word_t res);
        if (busy) begin
            return {res, dbg_pkg::ACK_WAIT};      // Old result with WAIT
        end
        return {res, ack};
    endfunction

    task automatic step(input logic t, input logic d);
        tms = t;
        tdi = d;
        @(posedge tck);
        #1;                                       // Drive just after the edge
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // Starts in Run-Test/Idle or Update-DR, ends in Run-Test/Idle
    task automatic shift_ir(input dbg_pkg::ir_t code);
        step(1'b1, 1'b0);
        step(1'b1, 1'b0);                         // Select-IR-Scan
        step(1'b0, 1'b0);
        step(1'b0, 1'b0);                         // Into Shift-IR
        for (int i = 0; i < 4; i++) begin
            step(i == 3, code[i]);
        end
        step(1'b1, 1'b0);                         // Update-IR
        step(1'b0, 1'b0);
    endtask

    // Idle 0 leaves the TAP in Update-DR for a direct rescan
    task automatic shift_dr(input int len, input logic [63:0] din,
                            input logic [63:0] expected, input int idle);
        int n;
        exp_word = expected;
        exp_len  = len;
        win_open = 1'b1;
        step(1'b1, 1'b0);                         // Select-DR-Scan
        step(1'b0, 1'b0);                         // Capture-DR
        step(1'b0, 1'b0);
        for (int i = 0; i < len; i++) begin
            step(i == len - 1, din[i]);
        end
        win_open = 1'b0;
        step(1'b1, 1'b0);                         // Exit1 to Update-DR
        n = 0;
        while (chk_active && n < 20) begin
            @(posedge tck);
            #1;
            n++;
        end
        if (chk_active) begin
            fail_timeout("the checker to finish a scan");
        end
        for (int j = 0; j < idle; j++) begin
            step(1'b0, 1'b0);
        end
    endtask

    // One CDPACC scan: check the capture, then issue the command
    task automatic cdp_cmd(input dbg_pkg::cdp_op_t op, input logic wr,
                           input dbg_pkg::dbg_word_t data, input int idle);
        logic [63:0]        expv;
        dbg_pkg::cdp_ack_t  nack;
        dbg_pkg::dbg_word_t nres;
        logic [7:0]         a;
        logic               err;
        expv = 64'(expected_capture(busy_m, ack_m, res_m));
        if (busy_m) begin
            ack_m  = pend_ack;                    // Transfer ends right after capture
            res_m  = pend_res;
            busy_m = 1'b0;
        end
        nack = ack_m;
        nres = res_m;
        case (op)
            dbg_pkg::CDP_OP_SELECT: begin
                if (wr) begin
                    sel_m = data;
                end else begin
                    nres = sel_m;
                    nack = dbg_pkg::ACK_OK;
                end
            end
            dbg_pkg::CDP_OP_TADDR: begin
                if (wr) begin
                    taddr_m = data;
                end else begin
                    nres = taddr_m;
                    nack = dbg_pkg::ACK_OK;
                end
            end
            dbg_pkg::CDP_OP_DTR: begin
                a   = taddr_m[7:0];
                err = (sel_m >= dbg_pkg::NR_BANKS) || (a[1:0] != 2'b00) || (a[7:5] != 3'b000);
                if (err) begin
                    nack = dbg_pkg::ACK_FAULT;
                    nres = '0;
                end else if (wr) begin
                    bank_m[sel_m[1:0]][a[4:2]] = data;
                    nack = dbg_pkg::ACK_OK;
                    nres = data;
                end else begin
                    nack = dbg_pkg::ACK_OK;
                    nres = bank_m[sel_m[1:0]][a[4:2]];
                end
            end
            default: begin
            end
        endcase
        if (op == dbg_pkg::CDP_OP_DTR && idle == 0) begin
            busy_m   = 1'b1;                      // Next capture lands at k+2
            pend_ack = nack;
            pend_res = nres;
        end else begin
            ack_m = nack;
            res_m = nres;
        end
        shift_dr(dbg_pkg::CDPACC_WIDTH, 64'({data, op, wr}), expv, idle);
    endtask

    initial begin
        logic [63:0]        byp;
        dbg_pkg::dbg_word_t d;
        int                 total;
        void'($urandom(79));
        state_test_logic_reset = 1'b1;
        tms      = 1'b1;
        tdi      = 1'b0;
        win_open = 1'b0;
        exp_word = '0;
        exp_len  = 0;
        for (int b = 0; b < dbg_pkg::NR_BANKS; b++) begin
            for (int w = 0; w < dbg_pkg::BANK_WORDS; w++) begin
                bank_m[b][w] = '0;
            end
        end
        sel_m   = '0;
        taddr_m = '0;
        res_m   = '0;
        ack_m   = dbg_pkg::ACK_OK;
        busy_m  = 1'b0;
        repeat (16) @(posedge tck);
        #1;
        state_test_logic_reset = 1'b0;
        step(1'b0, 1'b0);                         // To Run-Test/Idle

        shift_dr(32, '0, 64'(dbg_pkg::IDCODE_VALUE), 1);  // IDCODE after reset

        shift_ir(dbg_pkg::IR_BYPASS);
        byp = {$urandom, $urandom};
        shift_dr(33, byp, byp << 1, 1);           // One-bit delay
        shift_ir(dbg_pkg::IR_CDPACC);

        // Random writes to every bank, then read back
        for (int b = 0; b < dbg_pkg::NR_BANKS; b++) begin
            cdp_cmd(dbg_pkg::CDP_OP_SELECT, 1'b1, b, 4);
            for (int k = 0; k < 3; k++) begin
                wr_addr[b][k] = 8'($urandom_range(0, 7) << 2);
                cdp_cmd(dbg_pkg::CDP_OP_TADDR, 1'b1, 32'(wr_addr[b][k]), 4);
                cdp_cmd(dbg_pkg::CDP_OP_DTR, 1'b1, $urandom, 4);
            end
        end
        for (int b = 0; b < dbg_pkg::NR_BANKS; b++) begin
            cdp_cmd(dbg_pkg::CDP_OP_SELECT, 1'b1, b, 4);
            for (int k = 0; k < 3; k++) begin
                cdp_cmd(dbg_pkg::CDP_OP_TADDR, 1'b1, 32'(wr_addr[b][k]), 4);
                cdp_cmd(dbg_pkg::CDP_OP_DTR, 1'b0, '0, 4);
            end
        end
        cdp_cmd(OP_NOP, 1'b0, '0, 4);

        // Faults: no bank, misaligned, out of range
        cdp_cmd(dbg_pkg::CDP_OP_SELECT, 1'b1, 4 + $urandom_range(0, 11), 4);
        cdp_cmd(dbg_pkg::CDP_OP_TADDR, 1'b1, 32'h08, 4);
        cdp_cmd(dbg_pkg::CDP_OP_DTR, 1'b1, $urandom, 4);
        cdp_cmd(dbg_pkg::CDP_OP_SELECT, 1'b1, 1, 4);
        cdp_cmd(dbg_pkg::CDP_OP_TADDR, 1'b1, 32'(wr_addr[1][0] | 8'h01), 4);
        cdp_cmd(dbg_pkg::CDP_OP_DTR, 1'b1, $urandom, 4);
        cdp_cmd(dbg_pkg::CDP_OP_TADDR, 1'b1, 32'(wr_addr[1][0] | 8'h40), 4);
        cdp_cmd(dbg_pkg::CDP_OP_DTR, 1'b1, $urandom, 4);
        cdp_cmd(dbg_pkg::CDP_OP_DTR, 1'b0, '0, 4);
        cdp_cmd(dbg_pkg::CDP_OP_TADDR, 1'b1, 32'(wr_addr[1][0]), 4);
        cdp_cmd(dbg_pkg::CDP_OP_DTR, 1'b0, '0, 4); // Bank untouched
        cdp_cmd(OP_NOP, 1'b0, '0, 4);

        // Capture straight after Update-DR sees WAIT
        cdp_cmd(dbg_pkg::CDP_OP_SELECT, 1'b1, 2, 4);
        cdp_cmd(dbg_pkg::CDP_OP_TADDR, 1'b1, 32'(wr_addr[2][1]), 4);
        cdp_cmd(dbg_pkg::CDP_OP_DTR, 1'b0, '0, 0);
        cdp_cmd(OP_NOP, 1'b0, '0, 4);
        cdp_cmd(OP_NOP, 1'b0, '0, 4);

        // SELECT and TADDR read back
        d = $urandom;
        cdp_cmd(dbg_pkg::CDP_OP_SELECT, 1'b1, d, 4);
        d = $urandom;
        cdp_cmd(dbg_pkg::CDP_OP_TADDR, 1'b1, d, 4);
        cdp_cmd(dbg_pkg::CDP_OP_SELECT, 1'b0, '0, 4);
        cdp_cmd(dbg_pkg::CDP_OP_TADDR, 1'b0, '0, 4);
        cdp_cmd(OP_NOP, 1'b0, '0, 4);

        repeat (4) @(posedge tck);
        total = tdo_errs + len_errs + DUT.u_cdp.u_asserts.fail_cnt;
        $display("Scans %0d, tdo errors %0d, length errors %0d, assertion failures %0d",
                 scans, tdo_errs, len_errs, DUT.u_cdp.u_asserts.fail_cnt);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* jtag_dbg_top.f */
design/dbg_pkg.sv
design/jtag_tap.sv
design/core_dbg_port.sv
design/dbg_reg_bank.sv
design/dbg_resp_collector.sv
design/jtag_dbg_top.sv
sim/jtag_dbg_asserts.sv
sim/jtag_dbg_checker.sv
sim/jtag_dbg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the JTAG debug testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f jtag_dbg_top.f --top-module jtag_dbg_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vjtag_dbg_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
exit 1
